//--- common/fetch_pkg.sv
package fetch_pkg;

    // ============================================================
    // basic widths of the fetch stage
    // ============================================================

    // byte address of an instruction
    typedef logic [31:0] addr_t;
    // full 32-bit instruction word
    typedef logic [31:0] instr_t;
    // one 16-bit parcel, compressed instr or half of a 32-bit one
    typedef logic [15:0] half_t;

    // ============================================================
    // instruction memory
    // ============================================================

    // word index width, address bits 11:2
    localparam int IMEM_AW    = 10;
    localparam int IMEM_DEPTH = 1024;
    typedef logic [IMEM_AW-1:0] imem_idx_t;

    // image shared by memory model and testbench
    localparam string IMEM_INIT_FILE = "verification/program.hex";

    // ============================================================
    // prefetch buffer and output side
    // ============================================================

    // halfword slots in the prefetch buffer
    localparam int FIFO_DEPTH = 5;
    // occupancy 0..5
    typedef logic [2:0] fifo_cnt_t;
    // halfwords moved per cycle 0..2, write and drain
    typedef logic [1:0] hw_cnt_t;

    // addi x0, x0, 0
    localparam logic [31:0] NOP_INSTR = 32'h0000_0013;
    // forced nop cycles after reset release
    localparam int RESET_SETTLE = 2;

endpackage

//--- common/hw_fill_if.sv
`timescale 1ns/1ps

interface hw_fill_if
    import fetch_pkg::*;
();

    // empties the buffer, wins over a write in the same cycle
    logic    clear;
    // halfwords written this edge, 0 means idle
    hw_cnt_t wr_cnt;
    // older parcel, written first
    half_t   wr_lo;
    // younger parcel, only used when wr_cnt is 2
    half_t   wr_hi;

    // prefetch controller side
    modport ctrl (output clear, output wr_cnt, output wr_lo, output wr_hi);

    // buffer side
    modport fifo (input clear, input wr_cnt, input wr_lo, input wr_hi);

endinterface

//--- fetch_stage.f
common/fetch_pkg.sv
common/hw_fill_if.sv
hw/imem/imem_array.sv
hw/prefetch/prefetch_ctrl.sv
hw/prefetch/halfword_fifo.sv
hw/fetch_output.sv
hw/fetch_stage.sv
verification/fetch_stage_tb.sv

//--- hw/fetch_output.sv
`timescale 1ns/1ps

module fetch_output
    import fetch_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    // decode accepts the shown instruction
    input  logic      enable_i,
    // shown instruction is 16 bits
    input  logic      is_compress_i,
    // masks the output only
    input  logic      flush_i,
    input  fifo_cnt_t occupancy_i,
    input  instr_t    head_i,
    // parcels to remove at the next edge
    output hw_cnt_t   drain_cnt_o,
    output instr_t    instr_o
);

    // ============================================================
    // reset settle
    // ============================================================

    // counts up to RESET_SETTLE after release, then holds
    logic [$clog2(RESET_SETTLE+1)-1:0] settle_q;
    logic settled;
    // at least one full 32-bit window in the buffer
    logic avail;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            settle_q <= '0;
        end else if (!settled) begin
            settle_q <= settle_q + 1'b1;
        end
    end

    assign settled = (settle_q == RESET_SETTLE);

    // ============================================================
    // output and drain
    // ============================================================

    // a compressed instr only needs one parcel, but two are waited
    // for anyway so decode always sees a full window
    assign avail = settled && (occupancy_i >= 3'd2);

    // nop while not settled, flushed or short of data
    assign instr_o = (avail && !flush_i) ? head_i : NOP_INSTR;

    // drain keeps going under flush
    always_comb begin
        if (!(enable_i && avail)) begin
            drain_cnt_o = 2'd0;
        end else if (is_compress_i) begin
            drain_cnt_o = 2'd1;
        end else begin
            drain_cnt_o = 2'd2;
        end
    end

endmodule

//--- hw/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage
    import fetch_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n_i,
    // decode stall when low
    input  logic   enable_i,
    // redirect from decode
    input  logic   taken_i,
    input  addr_t  redirect_i,
    input  logic   is_compress_i,
    input  logic   flush_i,
    // instruction to decode
    output instr_t instr_o
);

    // ============================================================
    // internal wiring
    // ============================================================

    // memory port
    logic      rd_en;
    imem_idx_t rd_addr;
    instr_t    rd_data;

    // buffer status and drain
    fifo_cnt_t occupancy;
    instr_t    head;
    hw_cnt_t   drain_cnt;

    // prefetch to buffer
    hw_fill_if fill_if ();

    // ============================================================
    // instances
    // ============================================================

    imem_array u_imem (
        .clk       (clk),
        .rd_en_i   (rd_en),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data)
    );

    prefetch_ctrl u_prefetch (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .taken_i     (taken_i),
        .redirect_i  (redirect_i),
        .occupancy_i (occupancy),
        .rd_en_o     (rd_en),
        .rd_addr_o   (rd_addr),
        .rd_data_i   (rd_data),
        .fill        (fill_if.ctrl)
    );

    halfword_fifo u_fifo (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .fill        (fill_if.fifo),
        .drain_cnt_i (drain_cnt),
        .occupancy_o (occupancy),
        .head_o      (head)
    );

    fetch_output u_output (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .enable_i      (enable_i),
        .is_compress_i (is_compress_i),
        .flush_i       (flush_i),
        .occupancy_i   (occupancy),
        .head_i        (head),
        .drain_cnt_o   (drain_cnt),
        .instr_o       (instr_o)
    );

endmodule

//--- hw/imem/imem_array.sv
`timescale 1ns/1ps

module imem_array
    import fetch_pkg::*;
(
    input  logic      clk,
    // read strobe, one cycle per word
    input  logic      rd_en_i,
    // word index, not a byte address
    input  imem_idx_t rd_addr_i,
    // valid the cycle after rd_en_i
    output instr_t    rd_data_o
);

    // ============================================================
    // storage
    // ============================================================

    // behaves like a single-port sram macro
    // contents come from the program image only
    instr_t mem_q [0:IMEM_DEPTH-1];

    // program image load
    initial begin
        $readmemh(IMEM_INIT_FILE, mem_q);
    end

    // ============================================================
    // read port
    // ============================================================

    // one cycle latency
    // output holds its value while no read is strobed
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem_q[rd_addr_i];
        end
    end

    // no write port, instruction memory is read-only here
    // word layout in the image matches little-endian fetch:
    // bits 15:0 are the lower halfword address
    // bits 31:16 the halfword at address + 2

endmodule

//--- hw/prefetch/halfword_fifo.sv
`timescale 1ns/1ps

module halfword_fifo
    import fetch_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    // writes and clear from prefetch
    hw_fill_if.fifo   fill,
    // halfwords consumed by decode this edge
    input  hw_cnt_t   drain_cnt_i,
    output fifo_cnt_t occupancy_o,
    // oldest parcel in 15:0, next one in 31:16
    output instr_t    head_o
);

    // slot index 0..4
    typedef logic [2:0] ptr_t;

    // ============================================================
    // pointer arithmetic
    // ============================================================

    // advance modulo FIFO_DEPTH, step is 0..2
    function automatic ptr_t ptr_add(input ptr_t ptr, input hw_cnt_t step);
        logic [3:0] sum;
        sum = {1'b0, ptr} + {2'b00, step};
        if (sum >= 4'(FIFO_DEPTH)) begin
            sum = sum - 4'(FIFO_DEPTH);
        end
        return sum[2:0];
    endfunction

    // ============================================================
    // storage and state
    // ============================================================

    half_t     mem_q [0:FIFO_DEPTH-1];
    ptr_t      rd_ptr_q;
    ptr_t      wr_ptr_q;
    fifo_cnt_t count_q;

    // slots touched by this edge
    ptr_t      wr_ptr_nxt;
    ptr_t      rd_ptr_nxt;

    assign wr_ptr_nxt = ptr_add(wr_ptr_q, 2'd1);
    assign rd_ptr_nxt = ptr_add(rd_ptr_q, 2'd1);

    // parcel storage, pointers decide what is valid
    always_ff @(posedge clk) begin
        if (!fill.clear) begin
            if (fill.wr_cnt != 2'd0) begin
                mem_q[wr_ptr_q] <= fill.wr_lo;
            end
            if (fill.wr_cnt == 2'd2) begin
                mem_q[wr_ptr_nxt] <= fill.wr_hi;
            end
        end
    end

    // pointers and level
    // clear wins over both write and drain
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (fill.clear) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            rd_ptr_q <= ptr_add(rd_ptr_q, drain_cnt_i);
            wr_ptr_q <= ptr_add(wr_ptr_q, fill.wr_cnt);
            // drain only ever covers parcels already held
            count_q  <= count_q + fifo_cnt_t'(fill.wr_cnt) - fifo_cnt_t'(drain_cnt_i);
        end
    end

    // ============================================================
    // read side
    // ============================================================

    // upper half may be stale when occupancy is 1
    // output side masks that case
    assign head_o      = {mem_q[rd_ptr_nxt], mem_q[rd_ptr_q]};
    assign occupancy_o = count_q;

endmodule

//--- hw/prefetch/prefetch_ctrl.sv
`timescale 1ns/1ps

module prefetch_ctrl
    import fetch_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    // redirect from decode
    input  logic      taken_i,
    input  addr_t     redirect_i,
    // buffer level before this edge
    input  fifo_cnt_t occupancy_i,
    // memory request
    output logic      rd_en_o,
    output imem_idx_t rd_addr_o,
    input  instr_t    rd_data_i,
    // halfword writes into the buffer
    hw_fill_if.ctrl   fill
);

    // ============================================================
    // state
    // ============================================================

    // next word to request
    addr_t     fetch_addr_q;
    // read strobe to memory
    logic      rd_en_q;
    imem_idx_t rd_addr_q;
    // memory data valid this cycle
    logic      resp_vld_q;
    // redirect landed on the upper halfword
    logic      skip_lo_q;

    // redirect target rounded down to its word
    addr_t     redirect_word;
    // halfwords written now
    hw_cnt_t   wr_cnt;
    // buffer level plus everything still on its way
    logic [3:0] demand;
    // room for one more word
    logic      room;

    assign redirect_word = {redirect_i[31:2], 2'b00};

    // ============================================================
    // issue decision
    // ============================================================

    // count the return written now and the word in the memory
    // a new word lands two edges later, so 3 + 2 never exceeds 5
    assign demand = {1'b0, occupancy_i} + {2'b00, wr_cnt} + (rd_en_q ? 4'd2 : 4'd0);
    assign room   = (demand <= 4'd3);

    // control flags
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rd_en_q      <= 1'b0;
            resp_vld_q   <= 1'b0;
            skip_lo_q    <= 1'b0;
            fetch_addr_q <= '0;
        end else if (taken_i) begin
            // restart at the target, drop the read still in memory
            rd_en_q      <= 1'b1;
            resp_vld_q   <= 1'b0;
            skip_lo_q    <= redirect_i[1];
            fetch_addr_q <= redirect_word + 32'd4;
        end else begin
            rd_en_q    <= room;
            resp_vld_q <= rd_en_q;
            // only the first return after a redirect is partial
            if (resp_vld_q) begin
                skip_lo_q <= 1'b0;
            end
            if (room) begin
                fetch_addr_q <= fetch_addr_q + 32'd4;
            end
        end
    end

    // request address, qualified by rd_en_q
    always_ff @(posedge clk) begin
        if (taken_i) begin
            rd_addr_q <= redirect_word[11:2];
        end else if (room) begin
            rd_addr_q <= fetch_addr_q[11:2];
        end
    end

    assign rd_en_o   = rd_en_q;
    assign rd_addr_o = rd_addr_q;

    // ============================================================
    // fill path
    // ============================================================

    // partial return keeps only the upper parcel
    always_comb begin
        if (!resp_vld_q) begin
            wr_cnt = 2'd0;
        end else if (skip_lo_q) begin
            wr_cnt = 2'd1;
        end else begin
            wr_cnt = 2'd2;
        end
    end

    assign fill.clear  = taken_i;
    assign fill.wr_cnt = wr_cnt;
    assign fill.wr_lo  = skip_lo_q ? rd_data_i[31:16] : rd_data_i[15:0];
    assign fill.wr_hi  = rd_data_i[31:16];

endmodule

//--- verification/fetch_stage_tb.sv
`timescale 1ns/1ps

module fetch_stage_tb
    import fetch_pkg::*;
();

    // ============================================================
    // constants and signals
    // ============================================================

    localparam int RAND_SEED   = 59967;
    // cycles without progress before a wait gives up
    localparam int WAIT_LIMIT  = 20;
    // stalled cycles that let prefetch top up the buffer
    localparam int FILL_CYCLES = 8;

    logic   clk;
    logic   rst_n_i;
    logic   enable_i;
    logic   taken_i;
    addr_t  redirect_i;
    logic   is_compress_i;
    logic   flush_i;
    instr_t instr_o;

    // reference copy of the program image
    instr_t model_mem [0:IMEM_DEPTH-1];
    // byte address decode should see next
    addr_t  exp_addr;

    int errors;
    int checks;
    int tests_run;
    int tests_failed;
    int errors_at_start;

    fetch_stage dut0 (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .enable_i      (enable_i),
        .taken_i       (taken_i),
        .redirect_i    (redirect_i),
        .is_compress_i (is_compress_i),
        .flush_i       (flush_i),
        .instr_o       (instr_o)
    );

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // hard stop for a run that loses its way
    initial begin
        #100000;
        $display("simulation reached its time limit before the tests finished");
        $display("TESTBENCH FAILED");
        $finish;
    end

    // ============================================================
    // program model
    // ============================================================

    // little-endian parcel at a byte address
    function automatic half_t half_at(input addr_t addr);
        instr_t word;
        word = model_mem[addr[11:2]];
        return addr[1] ? word[31:16] : word[15:0];
    endfunction

    // low bits 11 mark a 32-bit instruction
    function automatic logic is_compressed(input addr_t addr);
        half_t parcel;
        parcel = half_at(addr);
        return (parcel[1:0] != 2'b11);
    endfunction

    // decode always sees two parcels
    function automatic instr_t expected_window(input addr_t addr);
        return {half_at(addr + 32'd2), half_at(addr)};
    endfunction

    function automatic addr_t next_addr(input addr_t addr);
        return is_compressed(addr) ? addr + 32'd2 : addr + 32'd4;
    endfunction

    // ============================================================
    // bookkeeping and checks
    // ============================================================

    task automatic start_test();
        errors_at_start = errors;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors > errors_at_start) begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errors_at_start);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic check_instr(input instr_t expected, input string what);
        checks++;
        assert (instr_o === expected) else begin
            $display("Fail %0t: %s, instr_o %h, expected %h at address %h",
                     $time, what, instr_o, expected, exp_addr);
            errors++;
        end
    endtask

    // taken seen at the next edge while decode stalls
    task automatic redirect_to(input addr_t target);
        @(posedge clk);
        enable_i   <= 1'b0;
        flush_i    <= 1'b0;
        taken_i    <= 1'b1;
        redirect_i <= target;
        @(posedge clk);
        taken_i    <= 1'b0;
        exp_addr = target;
    endtask

    // accept count instructions with optional random stalls
    task automatic follow_stream(input int count, input logic stalls, input string what);
        int done;
        int idle;
        int hold;
        done = 0;
        idle = 0;
        hold = 0;
        while ((done < count) && (idle < WAIT_LIMIT)) begin
            @(posedge clk);
            enable_i      <= (hold == 0);
            is_compress_i <= is_compressed(exp_addr);
            @(negedge clk);
            idle++;
            if (instr_o !== NOP_INSTR) begin
                check_instr(expected_window(exp_addr), what);
                if (enable_i) begin
                    // removed from the buffer at the coming edge
                    exp_addr = next_addr(exp_addr);
                    done++;
                    idle = 0;
                    hold = stalls ? int'($urandom % 6) : 0;
                end
            end
            if (!enable_i && (hold > 0)) begin
                hold--;
            end
        end
        assert (done == count) else begin
            $display("timeout in %s: no instruction at %h for %0d cycles",
                     what, exp_addr, WAIT_LIMIT);
            errors++;
        end
        // last accepted instruction drains on this edge
        @(posedge clk);
        enable_i <= 1'b0;
    endtask

    // ============================================================
    // directed tests
    // ============================================================

    task automatic reset_and_settle();
        int i;
        start_test();
        for (i = 0; i < 4; i++) begin
            @(posedge clk);
            @(negedge clk);
            check_instr(NOP_INSTR, "output during reset");
        end
        @(posedge clk);
        rst_n_i <= 1'b1;
        for (i = 0; i < RESET_SETTLE; i++) begin
            @(negedge clk);
            check_instr(NOP_INSTR, "output while settling");
            @(posedge clk);
        end
        finish_test("reset");
    endtask

    task automatic aligned_redirect();
        start_test();
        redirect_to(32'h0000_0000);
        follow_stream(8, 1'b0, "aligned stream");
        finish_test("aligned redirect");
    endtask

    task automatic mixed_stream();
        start_test();
        redirect_to(32'h0000_0020);
        follow_stream(14, 1'b0, "mixed stream");
        finish_test("mixed stream");
    endtask

    task automatic halfword_redirect();
        start_test();
        redirect_to(32'h0000_0042);
        follow_stream(12, 1'b0, "halfword redirect stream");
        finish_test("halfword redirect");
    endtask

    task automatic stalled_stream();
        start_test();
        redirect_to(32'h0000_0020);
        follow_stream(20, 1'b1, "stalled stream");
        finish_test("back-pressure");
    endtask

    task automatic flush_under_drain();
        int i;
        start_test();
        redirect_to(32'h0000_0000);
        follow_stream(4, 1'b0, "stream before flush");
        for (i = 0; i < FILL_CYCLES; i++) begin
            @(posedge clk);
        end
        // full buffer lets two accepts happen under the mask
        for (i = 0; i < 2; i++) begin
            @(posedge clk);
            flush_i       <= 1'b1;
            enable_i      <= 1'b1;
            is_compress_i <= is_compressed(exp_addr);
            @(negedge clk);
            check_instr(NOP_INSTR, "flush with decode running");
            exp_addr = next_addr(exp_addr);
        end
        for (i = 0; i < 3; i++) begin
            @(posedge clk);
            enable_i <= 1'b0;
            @(negedge clk);
            check_instr(NOP_INSTR, "flush with decode stalled");
        end
        @(posedge clk);
        flush_i <= 1'b0;
        follow_stream(6, 1'b0, "stream after flush");
        finish_test("flush");
    endtask

    // ============================================================
    // run
    // ============================================================

    initial begin
        rst_n_i       <= 1'b0;
        enable_i      <= 1'b0;
        taken_i       <= 1'b0;
        redirect_i    <= '0;
        is_compress_i <= 1'b0;
        flush_i       <= 1'b0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        exp_addr     = '0;
        void'($urandom(RAND_SEED));
        $readmemh(IMEM_INIT_FILE, model_mem);

        reset_and_settle();
        aligned_redirect();
        mixed_stream();
        halfword_redirect();
        stalled_stream();
        flush_under_drain();

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- verification/program.hex
// instruction image, one 32-bit word per entry, four words per line, word 0 first
// bits 15:0 of a word hold the parcel at the lower byte address
// 0x00-0x1f aligned 32-bit instructions
00100093 00200113 002081b3 40118233
0041a023 0001a283 00529463 00a00313
// 0x20-0x3f mixed stream, 32-bit instructions straddle words
03930085 410d0031 05338532 859300b5
050500c5 06134501 80820106 00d68693
// 0x40-0x5f c.nop first, so 0x42 starts a 32-bit instruction
07130001 070900e7 00f78793 08134785
87aa0108 01188893 08850805 01290913
// 0x60-0x7f tail of the program
013989b3 0a134a05 8a56015a 016a8a93
0b050a85 017b0b13 018b8b93 0c050b85
